//--- include/rx_dsp_cfg.svh
`ifndef RX_DSP_CFG_SVH
`define RX_DSP_CFG_SVH

// Lanes per word and ADC code format
`define CHANNEL_WIDTH        4
`define CODE_PRECISION       8

// FFE taps, weights and shift
// Tap counts must stay at or below CHANNEL_WIDTH + 1
`define FFE_LENGTH           3
`define WEIGHT_PRECISION     6
`define FFE_SHIFT_PRECISION  3
`define FFE_OUT_PRECISION    16

// Channel estimate
`define CHAN_DEPTH           3
`define CHAN_PRECISION       8
`define CHAN_SHIFT_PRECISION 3

`define ERROR_PRECISION      12
`define CODE_DELAY           1

`endif

//--- hw/rx_dsp_pkg.sv
`include "rx_dsp_cfg.svh"

package rx_dsp_pkg;

    // Lane element types, signed so selects keep their sign
    typedef logic signed [`CODE_PRECISION-1:0]    code_t;
    typedef logic signed [`WEIGHT_PRECISION-1:0]  weight_t;
    typedef logic signed [`FFE_OUT_PRECISION-1:0] ffe_out_t;
    typedef logic signed [`CHAN_PRECISION-1:0]    chan_tap_t;
    typedef logic signed [`ERROR_PRECISION-1:0]   error_t;

    // Lane 0 is the oldest sample of a word
    typedef struct packed {
        logic                         valid;
        code_t [`CHANNEL_WIDTH-1:0]   code;
    } code_word_t;

    typedef struct packed {
        logic                         valid;
        logic [`CHANNEL_WIDTH-1:0]    bits;
    } bit_word_t;

    typedef struct packed {
        logic                         valid;
        error_t [`CHANNEL_WIDTH-1:0]  err;
    } error_word_t;

    // Weights shared across all lanes
    typedef struct packed {
        weight_t [`FFE_LENGTH-1:0]        weight;
        logic [`FFE_SHIFT_PRECISION-1:0]  shift;
        ffe_out_t                         thresh;
    } ffe_cfg_t;

    typedef struct packed {
        chan_tap_t [`CHAN_DEPTH-1:0]      tap;
        logic [`CHAN_SHIFT_PRECISION-1:0] shift;
    } chan_cfg_t;

    typedef struct packed {
        ffe_cfg_t  ffe;
        chan_cfg_t chan;
    } dsp_cfg_t;

endpackage : rx_dsp_pkg

//--- hw/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line #(
    parameter type payload_t = rx_dsp_pkg::code_word_t,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  payload_t item_i,
    output payload_t taps_o [0:DEPTH]
);

    // stage_q[0] holds the most recent valid item
    payload_t stage_q [0:DEPTH-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (item_i.valid) begin
            stage_q[0] <= item_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Tap 0 is the live input
    always_comb begin
        taps_o[0] = item_i;
        for (int i = 0; i < DEPTH; i++) begin
            taps_o[i+1] = stage_q[i];
        end
    end

    // An unknown valid would silently freeze every stage
    shift_enable_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(item_i.valid)
    ) else $error("delay line shift enable is unknown");

endmodule : sample_delay_line

//--- hw/ffe_slicer.sv
`timescale 1ns/1ps
`include "rx_dsp_cfg.svh"

module ffe_slicer (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  rx_dsp_pkg::code_word_t cur_codes_i,
    input  rx_dsp_pkg::code_word_t prev_codes_i,
    input  rx_dsp_pkg::ffe_cfg_t   cfg_i,
    output rx_dsp_pkg::bit_word_t  bits_o
);

    localparam int SEQ_LEN = 2 * `CHANNEL_WIDTH;

    // Previous word first, then the current one
    rx_dsp_pkg::code_t    code_seq [SEQ_LEN];

    rx_dsp_pkg::ffe_out_t ffe_sum  [`CHANNEL_WIDTH];
    rx_dsp_pkg::ffe_out_t ffe_eq   [`CHANNEL_WIDTH];
    logic [`CHANNEL_WIDTH-1:0] slice_d;

    rx_dsp_pkg::bit_word_t bits_q;

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            code_seq[i]                  = prev_codes_i.code[i];
            code_seq[`CHANNEL_WIDTH + i] = cur_codes_i.code[i];
        end
    end

    // FIR per lane, weight k against the code k positions back
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            ffe_sum[i] = '0;
            for (int k = 0; k < `FFE_LENGTH; k++) begin
                ffe_sum[i] = ffe_sum[i]
                           + rx_dsp_pkg::ffe_out_t'(cfg_i.weight[k])
                           * rx_dsp_pkg::ffe_out_t'(code_seq[`CHANNEL_WIDTH + i - k]);
            end
        end
    end

    // Arithmetic scaling keeps the sign
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            ffe_eq[i] = ffe_sum[i] >>> cfg_i.shift;
        end
    end

    // Slicer, ties resolve to 1
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            slice_d[i] = (ffe_eq[i] >= cfg_i.thresh);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bits_q <= '0;
        end else begin
            bits_q.valid <= cur_codes_i.valid;
            bits_q.bits  <= slice_d;
        end
    end

    assign bits_o = bits_q;

    // Weights, shift and threshold are quasi-static
    cfg_stable_on_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cur_codes_i.valid |-> $stable(cfg_i)
    ) else $error("FFE configuration changed while a valid word was in flight");

endmodule : ffe_slicer

//--- hw/channel_error_calc.sv
`timescale 1ns/1ps
`include "rx_dsp_cfg.svh"

module channel_error_calc (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  rx_dsp_pkg::bit_word_t   bits_i,
    input  rx_dsp_pkg::code_word_t  codes_i,
    input  rx_dsp_pkg::chan_cfg_t   cfg_i,
    output rx_dsp_pkg::bit_word_t   bits_o,
    output rx_dsp_pkg::error_word_t error_o
);

    localparam int SEQ_LEN = 2 * `CHANNEL_WIDTH;

    rx_dsp_pkg::bit_word_t bit_taps [0:1];

    logic [SEQ_LEN-1:0]   sym_seq;
    rx_dsp_pkg::error_t   exp_sum  [`CHANNEL_WIDTH];
    rx_dsp_pkg::error_t   exp_code [`CHANNEL_WIDTH];
    rx_dsp_pkg::error_t   err_d    [`CHANNEL_WIDTH];

    rx_dsp_pkg::bit_word_t   bits_q;
    rx_dsp_pkg::error_word_t error_q;

    // Last valid bit word, for symbols that reach back one word
    sample_delay_line #(
        .payload_t (rx_dsp_pkg::bit_word_t),
        .DEPTH     (1)
    ) bit_hist (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .item_i   (bits_i),
        .taps_o   (bit_taps)
    );

    assign sym_seq = {bit_taps[0].bits, bit_taps[1].bits};

    // Bit 1 maps to +1, bit 0 to -1
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            exp_sum[i] = '0;
            for (int k = 0; k < `CHAN_DEPTH; k++) begin
                if (sym_seq[`CHANNEL_WIDTH + i - k]) begin
                    exp_sum[i] = exp_sum[i] + rx_dsp_pkg::error_t'(cfg_i.tap[k]);
                end else begin
                    exp_sum[i] = exp_sum[i] - rx_dsp_pkg::error_t'(cfg_i.tap[k]);
                end
            end
        end
    end

    // expected minus received
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            exp_code[i] = exp_sum[i] >>> cfg_i.shift;
            err_d[i]    = exp_code[i] - rx_dsp_pkg::error_t'(codes_i.code[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bits_q  <= '0;
            error_q <= '0;
        end else begin
            bits_q        <= bits_i;
            error_q.valid <= bits_i.valid;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                error_q.err[i] <= err_d[i];
            end
        end
    end

    assign bits_o  = bits_q;
    assign error_o = error_q;

    // Code history must already hold the word these bits were sliced from
    bits_have_codes: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        bits_i.valid |-> codes_i.valid
    ) else $error("valid bits arrived without an aligned valid code word");

endmodule : channel_error_calc

//--- hw/rx_dsp_datapath.sv
`timescale 1ns/1ps
`include "rx_dsp_cfg.svh"

module rx_dsp_datapath (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  rx_dsp_pkg::code_word_t  codes_i,
    input  rx_dsp_pkg::dsp_cfg_t    cfg_i,
    output rx_dsp_pkg::bit_word_t   bits_o,
    output rx_dsp_pkg::error_word_t error_o
);

    // Tap 0 live, tap 1 last valid word
    rx_dsp_pkg::code_word_t code_taps [0:`CODE_DELAY];

    // Sliced bits, one cycle behind the live word
    rx_dsp_pkg::bit_word_t  slice_bits;

    // ADC code history
    sample_delay_line #(
        .payload_t (rx_dsp_pkg::code_word_t),
        .DEPTH     (`CODE_DELAY)
    ) code_hist (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .item_i   (codes_i),
        .taps_o   (code_taps)
    );

    // Equalize the current word against the previous one and slice
    ffe_slicer ffe_slc (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cur_codes_i  (code_taps[0]),
        .prev_codes_i (code_taps[1]),
        .cfg_i        (cfg_i.ffe),
        .bits_o       (slice_bits)
    );

    // By now tap 1 holds the word the bits came from
    channel_error_calc chan_err (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bits_i   (slice_bits),
        .codes_i  (code_taps[1]),
        .cfg_i    (cfg_i.chan),
        .bits_o   (bits_o),
        .error_o  (error_o)
    );

endmodule : rx_dsp_datapath

//--- verif/rx_dsp_tb.sv
`timescale 1ns/1ps
`include "rx_dsp_cfg.svh"

module rx_dsp_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 16;
    localparam int GAP            = 4;
    localparam int DIRECTED_WORDS = 22;
    localparam int RAND_CFGS      = 6;
    localparam int BUBBLE_CFGS    = 4;
    localparam int WORDS_PER_CFG  = 50;
    localparam int DRAIN          = 6;
    localparam int SEQ_LEN        = 2 * `CHANNEL_WIDTH;

    // Upper bound, bubble phase has at most one bubble per word
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1
                                + 2 * (GAP + DIRECTED_WORDS)
                                + RAND_CFGS * (GAP + WORDS_PER_CFG)
                                + BUBBLE_CFGS * (GAP + 2 * WORDS_PER_CFG)
                                + DRAIN;

    logic                    clk = 1'b0;
    logic                    arst_n_i;
    rx_dsp_pkg::code_word_t  codes_i;
    rx_dsp_pkg::dsp_cfg_t    cfg_i;
    rx_dsp_pkg::bit_word_t   bits_o;
    rx_dsp_pkg::error_word_t error_o;

    // Expected results, in input order
    rx_dsp_pkg::bit_word_t   exp_bits_q  [$];
    rx_dsp_pkg::error_word_t exp_err_q   [$];
    int                      exp_stamp_q [$];

    // Model history, advances on valid words only
    rx_dsp_pkg::code_word_t  model_prev_codes = '0;
    logic [`CHANNEL_WIDTH-1:0] model_prev_bits = '0;

    rx_dsp_pkg::bit_word_t   exp_bits;
    rx_dsp_pkg::error_word_t exp_err;
    int                      exp_stamp;

    int cycle_cnt = 0;
    int n_in      = 0;
    int n_out     = 0;
    int checks    = 0;
    int errors    = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rx_dsp_datapath rx_dsp_datapath_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .codes_i  (codes_i),
        .cfg_i    (cfg_i),
        .bits_o   (bits_o),
        .error_o  (error_o)
    );

    task automatic compare_values(input logic signed [31:0] actual,
                                  input logic signed [31:0] expected,
                                  input string              what);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s got %0d, expected %0d",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    // Slicer rule, weight k on the code k positions back
    function automatic logic [`CHANNEL_WIDTH-1:0] ref_slice(
        input rx_dsp_pkg::code_word_t cur,
        input rx_dsp_pkg::code_word_t prev,
        input rx_dsp_pkg::ffe_cfg_t   c
    );
        int seq [SEQ_LEN];
        int acc;
        logic [`CHANNEL_WIDTH-1:0] b;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            seq[i]                  = $signed(prev.code[i]);
            seq[`CHANNEL_WIDTH + i] = $signed(cur.code[i]);
        end
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc = 0;
            for (int k = 0; k < `FFE_LENGTH; k++) begin
                acc = acc + $signed(c.weight[k]) * seq[`CHANNEL_WIDTH + i - k];
            end
            acc  = acc >>> c.shift;
            b[i] = (acc >= $signed(c.thresh));
        end
        return b;
    endfunction

    // Expected code from +1/-1 symbols, minus the received code
    function automatic rx_dsp_pkg::error_word_t ref_error(
        input logic [`CHANNEL_WIDTH-1:0] cur_bits,
        input logic [`CHANNEL_WIDTH-1:0] prev_bits,
        input rx_dsp_pkg::code_word_t    codes,
        input rx_dsp_pkg::chan_cfg_t     c
    );
        int sym [SEQ_LEN];
        int acc;
        rx_dsp_pkg::error_word_t e;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            sym[i]                  = prev_bits[i] ? 1 : -1;
            sym[`CHANNEL_WIDTH + i] = cur_bits[i] ? 1 : -1;
        end
        e.valid = 1'b1;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc = 0;
            for (int k = 0; k < `CHAN_DEPTH; k++) begin
                acc = acc + sym[`CHANNEL_WIDTH + i - k] * $signed(c.tap[k]);
            end
            acc = (acc >>> c.shift) - $signed(codes.code[i]);
            e.err[i] = acc[`ERROR_PRECISION-1:0];
        end
        return e;
    endfunction

    function automatic rx_dsp_pkg::code_word_t random_word();
        rx_dsp_pkg::code_word_t w;
        int r;
        w.valid = 1'b1;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            r = $urandom;
            w.code[i] = r[`CODE_PRECISION-1:0];
        end
        return w;
    endfunction

    function automatic rx_dsp_pkg::dsp_cfg_t random_cfg();
        rx_dsp_pkg::dsp_cfg_t c;
        int r;
        for (int k = 0; k < `FFE_LENGTH; k++) begin
            r = $urandom;
            c.ffe.weight[k] = r[`WEIGHT_PRECISION-1:0];
        end
        r = $urandom;
        c.ffe.shift = r[`FFE_SHIFT_PRECISION-1:0];
        r = $urandom_range(0, 127);
        r = r - 64;
        c.ffe.thresh = r[`FFE_OUT_PRECISION-1:0];
        for (int k = 0; k < `CHAN_DEPTH; k++) begin
            r = $urandom;
            c.chan.tap[k] = r[`CHAN_PRECISION-1:0];
        end
        r = $urandom;
        c.chan.shift = r[`CHAN_SHIFT_PRECISION-1:0];
        return c;
    endfunction

    task automatic drive_word(input rx_dsp_pkg::code_word_t w);
        rx_dsp_pkg::bit_word_t   b;
        rx_dsp_pkg::error_word_t e;
        @(negedge clk);
        codes_i = w;
        if (w.valid) begin
            b.valid = 1'b1;
            b.bits  = ref_slice(w, model_prev_codes, cfg_i.ffe);
            e       = ref_error(b.bits, model_prev_bits, w, cfg_i.chan);
            exp_bits_q.push_back(b);
            exp_err_q.push_back(e);
            exp_stamp_q.push_back(cycle_cnt);
            model_prev_codes = w;
            model_prev_bits  = b.bits;
            n_in++;
        end
    endtask

    // Garbage codes with valid low
    task automatic drive_bubble();
        rx_dsp_pkg::code_word_t w;
        w = random_word();
        w.valid = 1'b0;
        drive_word(w);
    endtask

    // New configuration inside a quiet gap
    task automatic apply_cfg(input rx_dsp_pkg::dsp_cfg_t c);
        repeat (GAP - 1) drive_bubble();
        cfg_i = c;
        drive_bubble();
    endtask

    always @(posedge clk) begin
        if (!arst_n_i) begin
            compare_values(bits_o.valid, 1'b0, "bits_o valid during reset");
            compare_values(error_o.valid, 1'b0, "error_o valid during reset");
        end else if ($isunknown({bits_o.valid, error_o.valid})) begin
            $display("output valid flag is unknown at %0t ns", $time);
            errors++;
        end else begin
            compare_values(error_o.valid, bits_o.valid, "error_o valid against bits_o valid");
            if (bits_o.valid) begin
                n_out++;
                if (exp_bits_q.size() == 0) begin
                    $display("valid output at %0t ns with no valid input pending", $time);
                    errors++;
                end else begin
                    exp_bits  = exp_bits_q.pop_front();
                    exp_err   = exp_err_q.pop_front();
                    exp_stamp = exp_stamp_q.pop_front();
                    compare_values(cycle_cnt - exp_stamp, 2, "latency in cycles");
                    for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                        compare_values(bits_o.bits[i], exp_bits.bits[i],
                                       $sformatf("bit lane %0d", i));
                        compare_values($signed(error_o.err[i]), $signed(exp_err.err[i]),
                                       $sformatf("error lane %0d", i));
                    end
                end
            end
        end
        cycle_cnt++;
    end

    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not finish", TOTAL_CYCLES + 100);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main_seq
        rx_dsp_pkg::dsp_cfg_t   c;
        rx_dsp_pkg::code_word_t w;
        int edge_codes [4];
        void'($urandom(32'he3ed1b19));
        edge_codes = '{127, -128, 0, -1};
        arst_n_i = 1'b1;
        codes_i  = '0;
        cfg_i    = '0;
        #1 arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Pass-through FFE, single channel tap
        c = '0;
        c.ffe.shift     = 2;
        c.ffe.weight[0] = 4;
        c.ffe.thresh    = 0;
        c.chan.tap[0]   = 40;
        c.chan.shift    = 1;
        apply_cfg(c);
        for (int n = 0; n < 2; n++) begin
            w = '0;
            w.valid = 1'b1;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                w.code[i] = edge_codes[(i + n) % 4];
            end
            drive_word(w);
        end
        repeat (DIRECTED_WORDS - 2) drive_word(random_word());

        // Zero channel estimate
        c.chan       = '0;
        c.chan.shift = 3;
        apply_cfg(c);
        repeat (DIRECTED_WORDS) drive_word(random_word());

        repeat (RAND_CFGS) begin
            apply_cfg(random_cfg());
            repeat (WORDS_PER_CFG) drive_word(random_word());
        end

        // Bubbles mixed into the stream
        repeat (BUBBLE_CFGS) begin
            apply_cfg(random_cfg());
            repeat (WORDS_PER_CFG) begin
                if ($urandom_range(0, 3) == 0) begin
                    drive_bubble();
                end
                drive_word(random_word());
            end
        end

        repeat (DRAIN) drive_bubble();

        if (n_out != n_in) begin
            $display("valid output count %0d differs from valid input count %0d", n_out, n_in);
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : rx_dsp_tb

//--- build.f
+incdir+include
hw/rx_dsp_pkg.sv
hw/sample_delay_line.sv
hw/ffe_slicer.sv
hw/channel_error_calc.sv
hw/rx_dsp_datapath.sv
verif/rx_dsp_tb.sv
